/* bench/his_builder_properties.sv */
`timescale 1ns/100ps
`include "his_builder_cfg.svh"

module his_builder_properties (
    input logic clk,
    input logic res,
    input logic clearing,
    input logic acq_count_finish,
    input logic bin_valid
);

    // set once the sweep has ended
    logic counting_seen;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            counting_seen <= 1'b0;
        end else if (!clearing) begin
            counting_seen <= 1'b1;
        end
    end

    // frame end is a one cycle pulse
    a_finish_single: assert property (@(posedge clk) disable iff (!res)
        acq_count_finish |=> !acq_count_finish)
        else $error("acq_count_finish held for more than one cycle");

    // no frame end while the previous bank is streaming
    a_no_overlap: assert property (@(posedge clk) disable iff (!res)
        bin_valid |-> !acq_count_finish)
        else $error("acq_count_finish during bin_valid");

    // frames longer than the readout window
    a_frame_len: assert property (@(posedge clk) disable iff (!res)
        acq_count_finish |=> (!acq_count_finish) [*(`HB_BINS + 4)])
        else $error("frame shorter than the readout window");

    // sweep only once per reset
    a_clear_once: assert property (@(posedge clk) disable iff (!res)
        counting_seen |-> !clearing)
        else $error("clearing rose again after counting began");

endmodule

bind his_builder_top his_builder_properties u_props (
    .clk              (clk),
    .res              (res),
    .clearing         (clearing),
    .acq_count_finish (acq_count_finish),
    .bin_valid        (bin_valid)
);

/* bench/his_builder_tb.sv */
`timescale 1ns/100ps
`include "his_builder_cfg.svh"

module his_builder_tb;

    localparam int CLEAR_CYCLES = 2 * `HB_BINS;
    localparam int FRAME_EVENTS = `HB_DATA_NUM * `HB_PIXEL_NUM * `HB_ACQ_NUM;
    localparam int COUNT_TOP    = (1 << `HB_COUNT_W) - 1;

    logic                    clk;
    logic                    res;
    logic                    wr_en;
    logic [`HB_CODE_W-1:0]   addr;
    logic                    clearing;
    logic                    his_num;
    logic                    acq_count_finish;
    logic                    bin_valid;
    his_mem_pkg::bin_index_t bin_index;
    his_mem_pkg::bin_count_t bin_count;

    // reference histogram indexed by bank then bin
    int   model [0:1][0:`HB_BINS-1];
    // finished bank as it should stream out
    int   snap [0:`HB_BINS-1];
    // counts from the X records
    int   x_exp [0:`HB_BINS-1];
    logic model_num;
    int   counted;
    int   since_reset;
    // ticks left until the frame end pulse
    // negative when no pulse is pending
    int   finish_in;
    int   acq_tick;

    his_builder_top u_dut (
        .clk              (clk),
        .res              (res),
        .wr_en            (wr_en),
        .addr             (addr),
        .clearing         (clearing),
        .his_num          (his_num),
        .acq_count_finish (acq_count_finish),
        .bin_valid        (bin_valid),
        .bin_index        (bin_index),
        .bin_count        (bin_count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            fail_stop($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // one clock with inputs changing 2 ns after the edge
    task automatic tick();
        @(posedge clk);
        #2;
        since_reset++;
        if (finish_in >= 0) begin
            finish_in--;
        end
        if (finish_in == 0) begin
            // bank swap comes with the pulse
            model_num = ~model_num;
            acq_tick  = since_reset;
        end
        check_val("clearing", clearing, since_reset < CLEAR_CYCLES);
        check_val("acq_count_finish", acq_count_finish, finish_in == 0);
        check_val("his_num", his_num, model_num);
        if (since_reset <= CLEAR_CYCLES) begin
            check_val("bin_valid", bin_valid, 0);
        end
    endtask

    task automatic collect_frame();
        int waited;
        int b;
        waited = 0;
        while (!bin_valid) begin
            assert (waited < 12) else fail_stop("wait for bin_valid gave up");
            tick();
            waited++;
        end
        check_val("bin_valid delay", since_reset - acq_tick, 3);
        for (b = 0; b < `HB_BINS; b++) begin
            check_val("bin_valid", bin_valid, 1);
            check_val("bin_index", bin_index, b);
            check_val("bin_count", bin_count, snap[b]);
            tick();
        end
        check_val("bin_valid", bin_valid, 0);
    endtask

    task automatic end_frame();
        int b;
        int gap;
        for (b = 0; b < `HB_BINS; b++) begin
            check_val($sformatf("x_exp[%0d]", b), x_exp[b], snap[b]);
            x_exp[b] = 0;
        end
        collect_frame();
        gap = 10 + ($urandom % 11);
        repeat (gap) tick();
    endtask

    task automatic send_event(input logic [`HB_CODE_W-1:0] code);
        int b;
        logic done;
        b    = code >> `HB_BIN_SHIFT;
        done = 1'b0;
        wr_en = 1'b1;
        addr  = code;
        // events during the sweep are dropped
        if (since_reset >= CLEAR_CYCLES) begin
            if (b < `HB_BINS && model[model_num][b] < COUNT_TOP) begin
                model[model_num][b]++;
            end
            counted++;
        end
        if (counted == FRAME_EVENTS) begin
            // pulse comes two edges after this strobe
            // finished bank is read and cleared
            counted   = 0;
            finish_in = 2;
            done      = 1'b1;
            for (b = 0; b < `HB_BINS; b++) begin
                snap[b]             = model[model_num][b];
                model[model_num][b] = 0;
            end
        end
        tick();
        wr_en = 1'b0;
        if (done) begin
            end_frame();
        end
    endtask

    initial begin
        int            fd;
        int            r;
        int            a;
        int            c;
        int            b;
        int unsigned   seed_val;
        logic [7:0]    kind;
        logic [2047:0] line;
        seed_val    = $urandom(32'hd6d7);
        res         = 1'b0;
        wr_en       = 1'b0;
        addr        = '0;
        model_num   = 1'b0;
        counted     = 0;
        since_reset = 0;
        finish_in   = -1;
        acq_tick    = 0;
        for (b = 0; b < `HB_BINS; b++) begin
            model[0][b] = 0;
            model[1][b] = 0;
            x_exp[b]    = 0;
        end
        repeat (10) @(posedge clk);
        #2;
        res = 1'b1;
        fd = $fopen("bench/his_builder_vectors.txt", "r");
        assert (fd != 0) else fail_stop("could not open the vector file");
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                r = $fgets(line, fd);
            end else if (kind == "E") begin
                r = $fscanf(fd, "%h", a);
                send_event(a[`HB_CODE_W-1:0]);
            end else if (kind == "I") begin
                r = $fscanf(fd, "%d", a);
                repeat (a) tick();
            end else if (kind == "X") begin
                r = $fscanf(fd, "%h %h", a, c);
                x_exp[a] = c;
            end else begin
                fail_stop("unknown record in the vector file");
            end
        end
        $fclose(fd);
        if (counted == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_stop("vector file ends inside a frame");
        end
    end

endmodule

/* bench/his_builder_vectors.txt */
# records: E code (hex time code) | I n (decimal idle cycles) | X bin count (hex)
# X records give the readout of the frame whose events follow them
E 08 E 10
I 12
# frame 1, bank 0, back-to-back hits and two out-of-range codes
X 0 2 X 1 3 X 2 1 X 3 1 X 4 2 X 5 1
E 00 E 07
E 08 E 0f E 09
I 2
E 28 E 30 E 3f
E 10 E 18 E 20 E 21
# frame 2, bank 1, bin 2 saturates
X 2 7 X 5 1 X 0 1
E 11 E 11 E 11 E 11 E 11 E 11 E 11 E 11 E 11
I 3
E 2a E 38 E 01
# frame 3, bank 0 again, old bins read zero
X 3 6
E 1a E 32 E 1a E 1a E 32 E 32
I 4
E 1a E 32 E 1a E 32 E 1a E 32

/* his_builder.f */
+incdir+hw
hw/his_seq_pkg.sv
hw/his_mem_pkg.sv
hw/his_event_decode.sv
hw/his_acq_sequencer.sv
hw/his_bin_memory.sv
hw/his_readout.sv
hw/his_builder_top.sv
bench/his_builder_properties.sv
bench/his_builder_tb.sv

/* hw/his_acq_sequencer.sv */
`timescale 1ns/100ps
`include "his_builder_cfg.svh"

module his_acq_sequencer (
    input  logic                    clk,
    input  logic                    res,
    input  his_seq_pkg::event_op_t  op,
    output logic                    clearing,
    output logic                    clr_en,
    output his_mem_pkg::bin_index_t clr_index,
    output logic                    his_num,
    output logic                    acq_count_finish
);

    localparam int IN_W  = (`HB_DATA_NUM > 1) ? $clog2(`HB_DATA_NUM) : 1;
    localparam int PIX_W = (`HB_PIXEL_NUM > 1) ? $clog2(`HB_PIXEL_NUM) : 1;
    localparam int ACQ_W = (`HB_ACQ_NUM > 1) ? $clog2(`HB_ACQ_NUM) : 1;

    his_seq_pkg::seq_state_t state;
    // second pass of the sweep
    logic                    sweep_pass;

    logic [IN_W-1:0]  input_count;
    logic [PIX_W-1:0] pixel_count;
    logic [ACQ_W-1:0] acq_count;

    logic counted;
    logic input_last;
    logic pixel_last;
    logic acq_last;

    // busy and idle ops never reach the counters
    assign counted = (op == his_seq_pkg::op_incr) || (op == his_seq_pkg::op_range);

    assign input_last = input_count == IN_W'(`HB_DATA_NUM - 1);
    assign pixel_last = pixel_count == PIX_W'(`HB_PIXEL_NUM - 1);
    assign acq_last   = acq_count == ACQ_W'(`HB_ACQ_NUM - 1);

    assign clearing = (state == his_seq_pkg::st_clear);
    // memory zeroes clr_index in both banks while sweeping
    assign clr_en   = clearing;

    // clear sweep, two passes over the bin range
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= his_seq_pkg::st_clear;
            sweep_pass <= 1'b0;
            clr_index  <= '0;
        end else if (state == his_seq_pkg::st_clear) begin
            if (clr_index == his_mem_pkg::bin_last) begin
                clr_index  <= '0;
                sweep_pass <= 1'b1;
                if (sweep_pass) begin
                    state <= his_seq_pkg::st_count;
                end
            end else begin
                clr_index <= clr_index + 1'b1;
            end
        end
    end

    // nested input / pixel / acquisition counters
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            input_count      <= '0;
            pixel_count      <= '0;
            acq_count        <= '0;
            his_num          <= 1'b0;
            acq_count_finish <= 1'b0;
        end else begin
            // single cycle pulse
            acq_count_finish <= 1'b0;
            if (counted) begin
                if (!input_last) begin
                    input_count <= input_count + 1'b1;
                end else begin
                    input_count <= '0;
                    if (!pixel_last) begin
                        pixel_count <= pixel_count + 1'b1;
                    end else begin
                        pixel_count <= '0;
                        if (!acq_last) begin
                            acq_count <= acq_count + 1'b1;
                        end else begin
                            // frame complete, swap banks
                            acq_count        <= '0;
                            his_num          <= ~his_num;
                            acq_count_finish <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

/* hw/his_bin_memory.sv */
`timescale 1ns/100ps
`include "his_builder_cfg.svh"

module his_bin_memory (
    input  logic                    clk,
    input  logic                    res,
    input  his_seq_pkg::event_op_t  op,
    input  his_mem_pkg::bin_index_t bin,
    input  logic                    his_num,
    input  logic                    clr_en,
    input  his_mem_pkg::bin_index_t clr_index,
    input  logic                    rd_en,
    input  his_mem_pkg::bin_index_t rd_index,
    output his_mem_pkg::bin_count_t rd_count
);

    // bank then bin
    his_mem_pkg::bin_count_t mem [0:1][0:`HB_BINS-1];

    // write stage of the increment pipeline
    logic                    s1_valid;
    logic                    s1_bank;
    his_mem_pkg::bin_index_t s1_bin;
    his_mem_pkg::bin_count_t s1_count;
    his_mem_pkg::bin_count_t s1_next;

    logic                    fwd_hit;
    his_mem_pkg::bin_count_t s0_count;
    // readout always works on the idle bank
    logic                    rd_bank;

    assign rd_bank = ~his_num;

    // saturating increment
    assign s1_next = (s1_count == his_mem_pkg::count_max) ? s1_count : s1_count + 1'b1;

    // same bin and bank still in the write stage
    // array not updated yet, take the pipeline value
    assign fwd_hit  = s1_valid && (s1_bank == his_num) && (s1_bin == bin);
    assign s0_count = fwd_hit ? s1_next : mem[his_num][bin];

    // read stage, capture bank with the op
    // his_num may toggle before the write lands
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= (op == his_seq_pkg::op_incr);
        end
    end

    always_ff @(posedge clk) begin
        if (op == his_seq_pkg::op_incr) begin
            s1_bank  <= his_num;
            s1_bin   <= bin;
            s1_count <= s0_count;
        end
    end

    // array writes
    // sweep, read-and-clear on the idle bank, increment on the active bank
    always_ff @(posedge clk) begin
        if (clr_en) begin
            mem[0][clr_index] <= '0;
            mem[1][clr_index] <= '0;
        end else begin
            if (rd_en) begin
                mem[rd_bank][rd_index] <= '0;
            end
            if (s1_valid) begin
                mem[s1_bank][s1_bin] <= s1_next;
            end
        end
    end

    // result one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_count <= mem[rd_bank][rd_index];
        end
    end

endmodule

/* hw/his_builder_cfg.svh */
`ifndef HIS_BUILDER_CFG_SVH
`define HIS_BUILDER_CFG_SVH

// time code coming in with each write strobe
`define HB_CODE_W     6
// low code bits dropped when forming the bin number
`define HB_BIN_SHIFT  3
// bin number width follows from the code
`define HB_BIN_W      (`HB_CODE_W - `HB_BIN_SHIFT)
// bins per bank, mapped bins at or above this are out of range
`define HB_BINS       6
// bin counter width, counts saturate at all ones
`define HB_COUNT_W    3

// frame shape: inputs per pixel, pixels per acquisition, acquisitions per frame
`define HB_DATA_NUM   2
`define HB_PIXEL_NUM  3
`define HB_ACQ_NUM    2

`endif

/* hw/his_builder_top.sv */
`timescale 1ns/100ps
`include "his_builder_cfg.svh"

module his_builder_top (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    wr_en,
    input  logic [`HB_CODE_W-1:0]   addr,
    output logic                    clearing,
    output logic                    his_num,
    output logic                    acq_count_finish,
    output logic                    bin_valid,
    output his_mem_pkg::bin_index_t bin_index,
    output his_mem_pkg::bin_count_t bin_count
);

    his_seq_pkg::event_op_t  op;
    his_mem_pkg::bin_index_t bin;
    logic                    clr_en;
    his_mem_pkg::bin_index_t clr_index;
    logic                    rd_en;
    his_mem_pkg::bin_index_t rd_index;
    his_mem_pkg::bin_count_t rd_count;

    // strobe and code to op and bin
    his_event_decode u_decode (
        .clk      (clk),
        .res      (res),
        .wr_en    (wr_en),
        .addr     (addr),
        .clearing (clearing),
        .op       (op),
        .bin      (bin)
    );

    // sweep, frame counting, bank swap
    his_acq_sequencer u_seq (
        .clk              (clk),
        .res              (res),
        .op               (op),
        .clearing         (clearing),
        .clr_en           (clr_en),
        .clr_index        (clr_index),
        .his_num          (his_num),
        .acq_count_finish (acq_count_finish)
    );

    // two histogram banks
    his_bin_memory u_mem (
        .clk       (clk),
        .res       (res),
        .op        (op),
        .bin       (bin),
        .his_num   (his_num),
        .clr_en    (clr_en),
        .clr_index (clr_index),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .rd_count  (rd_count)
    );

    // finished bank out after each frame
    his_readout u_readout (
        .clk              (clk),
        .res              (res),
        .acq_count_finish (acq_count_finish),
        .rd_en            (rd_en),
        .rd_index         (rd_index),
        .rd_count         (rd_count),
        .bin_valid        (bin_valid),
        .bin_index        (bin_index),
        .bin_count        (bin_count)
    );

endmodule

/* hw/his_event_decode.sv */
`timescale 1ns/100ps
`include "his_builder_cfg.svh"

module his_event_decode (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    wr_en,
    input  logic [`HB_CODE_W-1:0]   addr,
    input  logic                    clearing,
    output his_seq_pkg::event_op_t  op,
    output his_mem_pkg::bin_index_t bin
);

    // bin number is the upper part of the time code
    his_mem_pkg::bin_index_t code_bin;
    logic                    in_range;

    assign code_bin = addr[`HB_CODE_W-1:`HB_BIN_SHIFT];
    // top codes map past the last bin
    assign in_range = code_bin <= his_mem_pkg::bin_last;

    // event class, one cycle after the strobe
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            op <= his_seq_pkg::op_none;
        end else if (!wr_en) begin
            op <= his_seq_pkg::op_none;
        end else if (clearing) begin
            // banks are being swept, event is lost
            op <= his_seq_pkg::op_busy;
        end else if (!in_range) begin
            op <= his_seq_pkg::op_range;
        end else begin
            op <= his_seq_pkg::op_incr;
        end
    end

    // bin travels next to op
    // only meaningful with op_incr
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bin <= code_bin;
        end
    end

endmodule

/* hw/his_mem_pkg.sv */
`include "his_builder_cfg.svh"

package his_mem_pkg;

    // bin number within one bank
    typedef logic [`HB_BIN_W-1:0] bin_index_t;

    // per bin event count
    typedef logic [`HB_COUNT_W-1:0] bin_count_t;

    // saturation point of a bin
    localparam bin_count_t count_max = '1;

    // last valid bin of a bank
    localparam bin_index_t bin_last = bin_index_t'(`HB_BINS - 1);

endpackage

/* hw/his_readout.sv */
`timescale 1ns/100ps
`include "his_builder_cfg.svh"

module his_readout (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    acq_count_finish,
    output logic                    rd_en,
    output his_mem_pkg::bin_index_t rd_index,
    input  his_mem_pkg::bin_count_t rd_count,
    output logic                    bin_valid,
    output his_mem_pkg::bin_index_t bin_index,
    output his_mem_pkg::bin_count_t bin_count
);

    // frame end delayed by one cycle
    // gives the last increment of the old bank time to land
    logic start_dly;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            start_dly <= 1'b0;
            rd_en     <= 1'b0;
            rd_index  <= '0;
            bin_valid <= 1'b0;
        end else begin
            start_dly <= acq_count_finish;
            // count comes back one cycle after the read
            bin_valid <= rd_en;
            if (start_dly) begin
                rd_en    <= 1'b1;
                rd_index <= '0;
            end else if (rd_en) begin
                // walk bins 0 up to the last one
                if (rd_index == his_mem_pkg::bin_last) begin
                    rd_en <= 1'b0;
                end else begin
                    rd_index <= rd_index + 1'b1;
                end
            end
        end
    end

    // index delayed to line up with rd_count
    always_ff @(posedge clk) begin
        bin_index <= rd_index;
    end

    // count is already registered in the memory
    assign bin_count = rd_count;

endmodule

/* hw/his_seq_pkg.sv */
`include "his_builder_cfg.svh"

package his_seq_pkg;

    // sweep both banks first, then count events
    typedef enum logic {
        st_clear,
        st_count
    } seq_state_t;

    // decoded event class, registered by the decode stage
    typedef enum logic [1:0] {
        op_none,
        op_incr,
        // counted toward the frame but lands in no bin
        op_range,
        // arrived during the clear sweep, dropped
        op_busy
    } event_op_t;

endpackage
